// File: cam_reg_pkg.sv
/*
 * Register window definitions: bus widths, address map,
 * identity values and FIFO flag field positions
 */
package cam_reg_pkg;

    // Bus geometry
    localparam int unsigned ADDR_WIDTH = 9;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned GPIO_WIDTH = 8;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam logic [ADDR_WIDTH-1:0] REG_ID_ADR          = 9'h000;
    localparam logic [ADDR_WIDTH-1:0] REG_REV_ADR         = 9'h001;
    localparam logic [ADDR_WIDTH-1:0] REG_GPIO_IN_ADR     = 9'h002;
    localparam logic [ADDR_WIDTH-1:0] REG_GPIO_OUT_ADR    = 9'h003;
    localparam logic [ADDR_WIDTH-1:0] REG_GPIO_OE_ADR     = 9'h004;
    localparam logic [ADDR_WIDTH-1:0] REG_FIFO0_ACC_ADR   = 9'h040;
    localparam logic [ADDR_WIDTH-1:0] REG_FIFO0_FLAG_ADR  = 9'h041;
    localparam logic [ADDR_WIDTH-1:0] REG_FIFO1_ACC_ADR   = 9'h080;
    localparam logic [ADDR_WIDTH-1:0] REG_FIFO1_FLAG_ADR  = 9'h081;
    localparam logic [ADDR_WIDTH-1:0] REG_FIFO2_ACC_ADR   = 9'h100;
    localparam logic [ADDR_WIDTH-1:0] REG_FIFO2_FLAG_ADR  = 9'h101;
    localparam logic [ADDR_WIDTH-1:0] REG_ACTIVE_BANK_ADR = 9'h102;

    // Identity and reset values
    localparam logic [DATA_WIDTH-1:0] DEVICE_ID_VALUE    = 32'hF1F0_7E57;
    localparam logic [15:0]           REV_VALUE          = 16'h0100;
    localparam logic [DATA_WIDTH-1:0] DEFAULT_READ_VALUE = 32'hFABD_EFAC;
    localparam logic [GPIO_WIDTH-1:0] GPIO_OUT_RESET     = 8'h00;
    localparam logic [GPIO_WIDTH-1:0] GPIO_OE_RESET      = 8'h00;

    // Flag register layout, level is zero-extended from bit 8 up
    localparam int unsigned FLAG_EMPTY_BIT = 0;
    localparam int unsigned FLAG_FULL_BIT  = 1;
    localparam int unsigned FLAG_LEVEL_LSB = 8;

endpackage

// File: cam_pack_pkg.sv
/*
 * Camera packer definitions: packing state type,
 * beats per word, bank count and bank index type
 */
package cam_pack_pkg;

    // Bytes already collected for the word in progress
    typedef enum logic [1:0] {
        PACK_IDLE = 2'd0,
        PACK_8    = 2'd1,
        PACK_16   = 2'd2,
        PACK_24   = 2'd3
    } pack_state_t;

    localparam int unsigned BEATS_PER_WORD = 4;   // One byte per beat

    // ----------------------------------------
    // FIFO banks
    // ----------------------------------------
    localparam int unsigned NUM_BANKS = 3;

    typedef logic [1:0] bank_idx_t;

endpackage

// File: cam_word_packer.sv
/*
 * Camera beat packer: valid beat counting, word assembly,
 * free-running word count and per-bank push strobes
 */
`timescale 1ns/1ns

module cam_word_packer #(
    parameter int unsigned FIFO_DEPTH = 16
) (
    input  logic                             pclk_i,
    input  logic                             rst_i,
    input  logic                             vsync_i,
    input  logic                             href_i,
    output logic [31:0]                      word_o,
    output logic [cam_pack_pkg::NUM_BANKS-1:0] push_o,
    output cam_pack_pkg::bank_idx_t          active_bank_o
);
    import cam_pack_pkg::*;

    localparam int unsigned DEPTH_W = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W   = DEPTH_W + $bits(bank_idx_t);
    localparam int unsigned WRAP    = NUM_BANKS * FIFO_DEPTH;

    pack_state_t            state_q;
    logic                   beat_valid;
    logic                   last_beat;
    logic [CNT_W-1:0]       wcnt_q;      // Position within the bank rotation
    logic [31:0]            freerun_q;   // Words since reset
    logic [31:0]            word_q;
    logic [NUM_BANKS-1:0]   push_q;
    bank_idx_t              bank;

    assign beat_valid = href_i & vsync_i;
    assign last_beat  = beat_valid && (state_q == pack_state_t'(BEATS_PER_WORD - 1));
    assign bank       = wcnt_q[CNT_W-1:DEPTH_W];

    // ----------------------------------------
    // Packing FSM
    // ----------------------------------------
    always_ff @(posedge pclk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q <= PACK_IDLE;
        end
        else if (beat_valid)
        begin
            case (state_q)
                PACK_IDLE: state_q <= PACK_8;
                PACK_8:    state_q <= PACK_16;
                PACK_16:   state_q <= PACK_24;
                default:   state_q <= PACK_IDLE;   // Word complete
            endcase
        end
    end

    // Word counters and push strobe
    always_ff @(posedge pclk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            wcnt_q    <= '0;
            freerun_q <= '0;
            push_q    <= '0;
        end
        else
        begin
            push_q <= '0;
            if (last_beat)
            begin
                push_q[bank] <= 1'b1;
                freerun_q    <= freerun_q + 32'd1;
                if (wcnt_q == CNT_W'(WRAP - 1))
                    wcnt_q <= '0;
                else
                    wcnt_q <= wcnt_q + CNT_W'(1);
            end
        end
    end

    // Test pattern word, the count itself
    always_ff @(posedge pclk_i)
    begin
        if (last_beat)
            word_q <= freerun_q;
    end

    assign word_o        = word_q;
    assign push_o        = push_q;
    assign active_bank_o = bank;

endmodule

// File: cam_fifo.sv
/*
 * Synchronous show-ahead FIFO with empty, full and level
 */
`timescale 1ns/1ns

module cam_fifo #(
    parameter int unsigned DEPTH = 16
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       push_i,
    input  logic                       pop_i,
    input  logic [31:0]                din_i,
    output logic [31:0]                dout_o,
    output logic                       empty_o,
    output logic                       full_o,
    output logic [$clog2(DEPTH+1)-1:0] level_o
);

    localparam int unsigned AW    = $clog2(DEPTH);
    localparam int unsigned LVL_W = $clog2(DEPTH + 1);

    logic [31:0]      mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [LVL_W-1:0] level_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i & ~full_o;   // Dropped when full
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + AW'(1);
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + AW'(1);
            if (do_push && !do_pop)
                level_q <= level_q + LVL_W'(1);
            else if (do_pop && !do_push)
                level_q <= level_q - LVL_W'(1);
        end
    end

    // Storage
    always_ff @(posedge clk_i)
    begin
        if (do_push)
            mem[wr_ptr_q] <= din_i;
    end

    assign dout_o  = mem[rd_ptr_q];   // Head word
    assign empty_o = (level_q == '0);
    assign full_o  = (level_q == LVL_W'(DEPTH));
    assign level_o = level_q;

endmodule

// File: cam_reg_file.sv
/*
 * Register window: bus acknowledge, GPIO registers,
 * read data mux and FIFO pop strobes
 */
`timescale 1ns/1ns

module cam_reg_file #(
    parameter int unsigned FIFO_DEPTH = 16
) (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic [cam_reg_pkg::ADDR_WIDTH-1:0]     wbs_adr_i,
    input  logic                                   wbs_cyc_i,
    input  logic                                   wbs_stb_i,
    input  logic                                   wbs_we_i,
    input  logic [3:0]                             wbs_byte_stb_i,
    input  logic [cam_reg_pkg::DATA_WIDTH-1:0]     wbs_dat_i,
    input  logic [cam_reg_pkg::GPIO_WIDTH-1:0]     gpio_in_i,
    input  logic [cam_pack_pkg::NUM_BANKS-1:0][31:0] fifo_dout_i,
    input  logic [cam_pack_pkg::NUM_BANKS-1:0]     fifo_empty_i,
    input  logic [cam_pack_pkg::NUM_BANKS-1:0]     fifo_full_i,
    input  logic [cam_pack_pkg::NUM_BANKS-1:0][$clog2(FIFO_DEPTH+1)-1:0] fifo_level_i,
    input  cam_pack_pkg::bank_idx_t                active_bank_i,
    output logic [cam_reg_pkg::DATA_WIDTH-1:0]     wbs_dat_o,
    output logic                                   wbs_ack_o,
    output logic [cam_reg_pkg::GPIO_WIDTH-1:0]     gpio_out_o,
    output logic [cam_reg_pkg::GPIO_WIDTH-1:0]     gpio_oe_o,
    output logic [cam_pack_pkg::NUM_BANKS-1:0]     pop_o
);
    import cam_reg_pkg::*;
    import cam_pack_pkg::*;

    localparam int unsigned LVL_W = $clog2(FIFO_DEPTH + 1);

    // Per-bank addresses, bank 0 in the low slot
    localparam logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0] ACC_ADR =
        {REG_FIFO2_ACC_ADR, REG_FIFO1_ACC_ADR, REG_FIFO0_ACC_ADR};
    localparam logic [NUM_BANKS-1:0][ADDR_WIDTH-1:0] FLAG_ADR =
        {REG_FIFO2_FLAG_ADR, REG_FIFO1_FLAG_ADR, REG_FIFO0_FLAG_ADR};

    logic                                  ack_q;
    logic                                  wr_cycle;
    logic                                  gpio_out_wr;
    logic                                  gpio_oe_wr;
    logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]  flag_word;
    logic [DATA_WIDTH-1:0]                 rd_data;

    // ----------------------------------------
    // Acknowledge and write decode
    // ----------------------------------------
    assign wr_cycle    = wbs_cyc_i & wbs_stb_i & wbs_we_i & ~ack_q & wbs_byte_stb_i[0];
    assign gpio_out_wr = wr_cycle & (wbs_adr_i == REG_GPIO_OUT_ADR);
    assign gpio_oe_wr  = wr_cycle & (wbs_adr_i == REG_GPIO_OE_ADR);

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            ack_q      <= 1'b0;
            gpio_out_o <= GPIO_OUT_RESET;
            gpio_oe_o  <= GPIO_OE_RESET;
        end
        else
        begin
            ack_q <= wbs_cyc_i & wbs_stb_i & ~ack_q;   // One-cycle ack
            if (gpio_out_wr)
                gpio_out_o <= wbs_dat_i[GPIO_WIDTH-1:0];
            if (gpio_oe_wr)
                gpio_oe_o <= wbs_dat_i[GPIO_WIDTH-1:0];
        end
    end

    // ----------------------------------------
    // Flag words and read mux
    // ----------------------------------------
    always_comb
    begin
        for (int k = 0; k < NUM_BANKS; k++)
        begin
            flag_word[k]                        = '0;
            flag_word[k][FLAG_EMPTY_BIT]        = fifo_empty_i[k];
            flag_word[k][FLAG_FULL_BIT]         = fifo_full_i[k];
            flag_word[k][FLAG_LEVEL_LSB +: LVL_W] = fifo_level_i[k];
        end
    end

    always_comb
    begin
        case (wbs_adr_i)
            REG_ID_ADR:          rd_data = DEVICE_ID_VALUE;
            REG_REV_ADR:         rd_data = DATA_WIDTH'(REV_VALUE);
            REG_GPIO_IN_ADR:     rd_data = DATA_WIDTH'(gpio_in_i);
            REG_GPIO_OUT_ADR:    rd_data = DATA_WIDTH'(gpio_out_o);
            REG_GPIO_OE_ADR:     rd_data = DATA_WIDTH'(gpio_oe_o);
            REG_ACTIVE_BANK_ADR: rd_data = DATA_WIDTH'(active_bank_i);
            default:
            begin
                rd_data = DEFAULT_READ_VALUE;
                for (int k = 0; k < NUM_BANKS; k++)
                begin
                    if (wbs_adr_i == ACC_ADR[k])
                        rd_data = fifo_empty_i[k] ? '0 : fifo_dout_i[k];   // Empty reads zero
                    if (wbs_adr_i == FLAG_ADR[k])
                        rd_data = flag_word[k];
                end
            end
        endcase
    end

    // Pop on the ack cycle, so the word shown is the one removed
    always_comb
    begin
        for (int k = 0; k < NUM_BANKS; k++)
            pop_o[k] = ack_q & ~wbs_we_i & (wbs_adr_i == ACC_ADR[k]) & ~fifo_empty_i[k];
    end

    assign wbs_dat_o = rd_data;
    assign wbs_ack_o = ack_q;

endmodule

// File: cam_capture_top.sv
/*
 * Camera capture top: packer, three FIFO banks, register window
 */
`timescale 1ns/1ns

module cam_capture_top #(
    parameter int unsigned FIFO_DEPTH = 16
) (
    input  logic                               PCLKI,
    input  logic                               WBs_RST_i,
    input  logic [cam_reg_pkg::ADDR_WIDTH-1:0] wbs_adr_i,
    input  logic                               wbs_cyc_i,
    input  logic                               wbs_stb_i,
    input  logic                               wbs_we_i,
    input  logic [3:0]                         wbs_byte_stb_i,
    input  logic [cam_reg_pkg::DATA_WIDTH-1:0] wbs_dat_i,
    output logic [cam_reg_pkg::DATA_WIDTH-1:0] wbs_dat_o,
    output logic                               wbs_ack_o,
    input  logic                               VSYNCI,
    input  logic                               HREFI,
    input  logic [cam_reg_pkg::GPIO_WIDTH-1:0] GPIO_IN_i,
    output logic [cam_reg_pkg::GPIO_WIDTH-1:0] GPIO_OUT_o,
    output logic [cam_reg_pkg::GPIO_WIDTH-1:0] GPIO_OE_o
);
    import cam_pack_pkg::*;

    localparam int unsigned LVL_W = $clog2(FIFO_DEPTH + 1);

    logic [31:0]                       word;
    logic [NUM_BANKS-1:0]              push;
    logic [NUM_BANKS-1:0]              pop;
    bank_idx_t                         active_bank;
    logic [NUM_BANKS-1:0][31:0]        fifo_dout;
    logic [NUM_BANKS-1:0]              fifo_empty;
    logic [NUM_BANKS-1:0]              fifo_full;
    logic [NUM_BANKS-1:0][LVL_W-1:0]   fifo_level;

    cam_word_packer #(.FIFO_DEPTH(FIFO_DEPTH)) u_packer (
        .pclk_i        (PCLKI),
        .rst_i         (WBs_RST_i),
        .vsync_i       (VSYNCI),
        .href_i        (HREFI),
        .word_o        (word),
        .push_o        (push),
        .active_bank_o (active_bank)
    );

    // One FIFO per bank, all fed the same word
    for (genvar k = 0; k < NUM_BANKS; k++)
    begin : g_bank
        cam_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
            .clk_i   (PCLKI),
            .rst_i   (WBs_RST_i),
            .push_i  (push[k]),
            .pop_i   (pop[k]),
            .din_i   (word),
            .dout_o  (fifo_dout[k]),
            .empty_o (fifo_empty[k]),
            .full_o  (fifo_full[k]),
            .level_o (fifo_level[k])
        );
    end

    cam_reg_file #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
        .clk_i          (PCLKI),
        .rst_i          (WBs_RST_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_byte_stb_i (wbs_byte_stb_i),
        .wbs_dat_i      (wbs_dat_i),
        .gpio_in_i      (GPIO_IN_i),
        .fifo_dout_i    (fifo_dout),
        .fifo_empty_i   (fifo_empty),
        .fifo_full_i    (fifo_full),
        .fifo_level_i   (fifo_level),
        .active_bank_i  (active_bank),
        .wbs_dat_o      (wbs_dat_o),
        .wbs_ack_o      (wbs_ack_o),
        .gpio_out_o     (GPIO_OUT_o),
        .gpio_oe_o      (GPIO_OE_o),
        .pop_o          (pop)
    );

endmodule

// File: cam_capture_tb_tasks.svh
/*
 * Testbench tasks for value checks, bus writes and reads with ack wait,
 * and camera word feed with random invalid beats
 */
`ifndef CAM_CAPTURE_TB_TASKS_SVH
`define CAM_CAPTURE_TB_TASKS_SVH

// Count a check and report a mismatch
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
        mismatches++;
        $display("Fail %s: expected %08h, actual %08h", name, expected, actual);
    end
endtask

// Sampled on falling edges away from the DUT's update edge
task automatic wait_ack(input string name);
    int waited;
    waited = 0;
    @(negedge pclk);
    while (!wbs_ack && waited < ACK_TIMEOUT)
    begin
        @(negedge pclk);
        waited++;
    end
    if (!wbs_ack)
    begin
        timeouts++;
        $display("Timeout in %s: no bus acknowledge within %0d cycles", name, ACK_TIMEOUT);
    end
endtask

// Ack is a single-cycle pulse
task automatic check_ack_dropped(input string name);
    @(negedge pclk);
    if (wbs_ack)
    begin
        other_errors++;
        $display("Bus acknowledge in %s stayed high for more than one cycle", name);
    end
endtask

// ----------------------------------------
// Bus cycles
// ----------------------------------------
task automatic bus_write(input logic [ADDR_WIDTH-1:0] adr, input logic [31:0] data,
                         input logic [3:0] strb, input string name);
    repeat ($urandom % 3) @(posedge pclk);   // Idle gap
    @(posedge pclk);
    wbs_adr      <= adr;
    wbs_dat_w    <= data;
    wbs_byte_stb <= strb;
    wbs_we       <= 1'b1;
    wbs_cyc      <= 1'b1;
    wbs_stb      <= 1'b1;
    wait_ack(name);
    @(posedge pclk);
    wbs_cyc <= 1'b0;
    wbs_stb <= 1'b0;
    wbs_we  <= 1'b0;
    check_ack_dropped(name);
endtask

task automatic bus_read(input logic [ADDR_WIDTH-1:0] adr, output logic [31:0] data,
                        input string name);
    repeat ($urandom % 3) @(posedge pclk);
    @(posedge pclk);
    wbs_adr <= adr;
    wbs_we  <= 1'b0;
    wbs_cyc <= 1'b1;
    wbs_stb <= 1'b1;
    wait_ack(name);
    data = wbs_dat_r;   // Valid while ack is high
    @(posedge pclk);
    wbs_cyc <= 1'b0;
    wbs_stb <= 1'b0;
    check_ack_dropped(name);
endtask

// Successive reads of one bank with each word one above the last
task automatic read_run(input logic [ADDR_WIDTH-1:0] adr, input int count,
                        input logic [31:0] first, input string name);
    logic [31:0] rd;
    for (int i = 0; i < count; i++)
    begin
        bus_read(adr, rd, name);
        check_value($sformatf("%s word %0d", name, i), first + 32'(i), rd);
    end
endtask

// ----------------------------------------
// Camera side
// ----------------------------------------
task automatic drive_invalid_beat();
    case ($urandom % 3)
        0:
        begin
            href  <= 1'b1;
            vsync <= 1'b0;
        end
        1:
        begin
            href  <= 1'b0;
            vsync <= 1'b1;
        end
        default:
        begin
            href  <= 1'b0;
            vsync <= 1'b0;
        end
    endcase
endtask

task automatic feed_words(input int count);
    for (int w = 0; w < count * BEATS; w++)
    begin
        repeat ($urandom % 3)
        begin
            @(posedge pclk);
            drive_invalid_beat();
        end
        @(posedge pclk);
        href  <= 1'b1;
        vsync <= 1'b1;
    end
    @(posedge pclk);
    href  <= 1'b0;
    vsync <= 1'b0;
    @(posedge pclk);   // Last word stored at this edge
endtask

`endif

// File: cam_capture_tb.sv
/*
 * Camera capture testbench: clock, reset, DUT,
 * stimulus file interpreter and result summary
 */
`timescale 1ns/1ns

module cam_capture_tb;
    import cam_reg_pkg::*;

    localparam int FIFO_DEPTH  = 16;
    localparam int BEATS       = 4;    // Valid camera beats per word
    localparam int ACK_TIMEOUT = 20;
    localparam int STIM_LINES  = 80;
    localparam int STIM_COLS   = 5;

    // Stimulus operation codes
    localparam logic [31:0] OP_END      = 32'd0;
    localparam logic [31:0] OP_GPIO_IN  = 32'd1;
    localparam logic [31:0] OP_WRITE    = 32'd2;
    localparam logic [31:0] OP_READ     = 32'd3;
    localparam logic [31:0] OP_RUN      = 32'd4;
    localparam logic [31:0] OP_CAMERA   = 32'd5;
    localparam logic [31:0] OP_OUT_PINS = 32'd6;
    localparam logic [31:0] OP_OE_PINS  = 32'd7;

    logic                  pclk;
    logic                  wbs_rst;
    logic [ADDR_WIDTH-1:0] wbs_adr;
    logic                  wbs_cyc;
    logic                  wbs_stb;
    logic                  wbs_we;
    logic [3:0]            wbs_byte_stb;
    logic [DATA_WIDTH-1:0] wbs_dat_w;
    logic [DATA_WIDTH-1:0] wbs_dat_r;
    logic                  wbs_ack;
    logic                  vsync;
    logic                  href;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic [GPIO_WIDTH-1:0] gpio_oe;

    logic [31:0] stim [STIM_LINES*STIM_COLS];
    int          checks;
    int          mismatches;
    int          timeouts;
    int          other_errors;

    cam_capture_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
        .PCLKI          (pclk),
        .WBs_RST_i      (wbs_rst),
        .wbs_adr_i      (wbs_adr),
        .wbs_cyc_i      (wbs_cyc),
        .wbs_stb_i      (wbs_stb),
        .wbs_we_i       (wbs_we),
        .wbs_byte_stb_i (wbs_byte_stb),
        .wbs_dat_i      (wbs_dat_w),
        .wbs_dat_o      (wbs_dat_r),
        .wbs_ack_o      (wbs_ack),
        .VSYNCI         (vsync),
        .HREFI          (href),
        .GPIO_IN_i      (gpio_in),
        .GPIO_OUT_o     (gpio_out),
        .GPIO_OE_o      (gpio_oe)
    );

    `include "cam_capture_tb_tasks.svh"

    function automatic string test_name(input logic [31:0] id);
        case (id)
            1:       return "identity";
            2:       return "gpio";
            3:       return "bank0_fill";
            4:       return "rotation";
            5:       return "overflow";
            default: return "unnamed";
        endcase
    endfunction

    initial
    begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    // ----------------------------------------
    // Stimulus file interpreter
    // ----------------------------------------
    initial
    begin
        int                    line;
        int                    ops_run;
        logic [31:0]           op;
        logic [ADDR_WIDTH-1:0] adr;
        logic [31:0]           data;
        logic [31:0]           expected;
        logic [31:0]           rd;
        string                 name;

        void'($urandom(92299));
        wbs_rst      = 1'b1;
        wbs_adr      = '0;
        wbs_cyc      = 1'b0;
        wbs_stb      = 1'b0;
        wbs_we       = 1'b0;
        wbs_byte_stb = 4'h0;
        wbs_dat_w    = '0;
        vsync        = 1'b0;
        href         = 1'b0;
        gpio_in      = '0;
        checks       = 0;
        mismatches   = 0;
        timeouts     = 0;
        other_errors = 0;
        for (int i = 0; i < STIM_LINES * STIM_COLS; i++)
            stim[i] = '0;   // Unread lines act as the end marker
        $readmemh("cam_capture_stimulus.txt", stim);

        repeat (4) @(posedge pclk);
        wbs_rst <= 1'b0;

        line    = 0;
        ops_run = 0;
        while (line < STIM_LINES && stim[line*STIM_COLS+1] != OP_END)
        begin
            op       = stim[line*STIM_COLS+1];
            adr      = stim[line*STIM_COLS+2][ADDR_WIDTH-1:0];
            data     = stim[line*STIM_COLS+3];
            expected = stim[line*STIM_COLS+4];
            name     = $sformatf("%s step %0d", test_name(stim[line*STIM_COLS]), line);
            case (op)
                OP_GPIO_IN:
                begin
                    @(posedge pclk);
                    gpio_in <= data[GPIO_WIDTH-1:0];
                end
                OP_WRITE:    bus_write(adr, data, expected[3:0], name);
                OP_READ:
                begin
                    bus_read(adr, rd, name);
                    check_value(name, expected, rd);
                end
                OP_RUN:      read_run(adr, int'(data), expected, name);
                OP_CAMERA:   feed_words(int'(data));
                OP_OUT_PINS:
                begin
                    @(negedge pclk);
                    check_value(name, expected, 32'(gpio_out));
                end
                OP_OE_PINS:
                begin
                    @(negedge pclk);
                    check_value(name, expected, 32'(gpio_oe));
                end
                default:
                begin
                    other_errors++;
                    $display("Unknown operation %0d in stimulus step %0d", op, line);
                end
            endcase
            ops_run++;
            line++;
        end
        if (ops_run == 0)
        begin
            other_errors++;
            $display("No operations were read from the stimulus file");
        end

        $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d other errors",
                 checks, mismatches, timeouts, other_errors);
        if (mismatches == 0 && timeouts == 0 && other_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: cam_capture_stimulus.txt
// Columns, all hex: test op address data expected
// Ops: 1 GPIO input, 2 write (expected is byte strobe), 3 read, 4 read run
//      (data reads counting up from expected), 5 camera words, 6/7 out/oe pins, 0 end
// Identity and default reads
1 1 000 000000A5 00000000
1 3 000 00000000 F1F07E57
1 3 001 00000000 00000100
1 3 002 00000000 000000A5
1 3 005 00000000 FABDEFAC
1 3 1FF 00000000 FABDEFAC
// GPIO registers and pins
2 6 000 00000000 00000000
2 7 000 00000000 00000000
2 2 003 0000003C 0000000F
2 2 004 000000F0 00000001
2 3 003 00000000 0000003C
2 3 004 00000000 000000F0
2 6 000 00000000 0000003C
2 7 000 00000000 000000F0
2 2 003 000000FF 0000000E
2 2 004 00000000 0000000E
2 3 003 00000000 0000003C
2 3 004 00000000 000000F0
2 6 000 00000000 0000003C
2 7 000 00000000 000000F0
// Bank 0 fill and drain
3 3 102 00000000 00000000
3 3 041 00000000 00000001
3 3 040 00000000 00000000
3 5 000 00000005 00000000
3 3 041 00000000 00000500
3 4 040 00000005 00000000
3 3 041 00000000 00000001
// Bank rotation
4 5 000 0000000B 00000000
4 3 102 00000000 00000001
4 3 041 00000000 00000B00
4 4 040 0000000B 00000005
4 5 000 00000010 00000000
4 3 102 00000000 00000002
4 3 081 00000000 00001002
4 4 080 00000010 00000010
4 3 081 00000000 00000001
4 5 000 00000010 00000000
4 3 102 00000000 00000000
4 3 101 00000000 00001002
4 4 100 00000010 00000020
4 5 000 00000001 00000000
4 3 041 00000000 00000100
4 4 040 00000001 00000030
// Overfill bank 1, later words keep their count
5 5 000 0000000F 00000000
5 4 040 0000000F 00000031
5 5 000 00000030 00000000
5 5 000 00000010 00000000
5 3 081 00000000 00001002
5 4 080 00000010 00000040
5 3 080 00000000 00000000
5 3 081 00000000 00000001
5 3 041 00000000 00001002
5 4 040 00000010 00000060
5 4 100 00000010 00000050
5 5 000 00000001 00000000
5 3 102 00000000 00000002
5 4 100 00000001 00000080
0 0 000 00000000 00000000

// File: cam_capture.f
+incdir+.
cam_reg_pkg.sv
cam_pack_pkg.sv
cam_word_packer.sv
cam_fifo.sv
cam_reg_file.sv
cam_capture_top.sv
cam_capture_tb.sv

// File: Makefile
TOP := cam_capture_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

obj_dir/V$(TOP): cam_capture.f *.sv *.svh
	verilator --binary --timing -f cam_capture.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f cam_capture.f --top-module $(TOP)

clean:
	rm -rf obj_dir
